//--- logic/cop_consts.svh
//////////////////////////////////////////////////
// Encoding constants for the coprocessor: opcode,
// CPR count and result codes. Include where needed.
//////////////////////////////////////////////////

`ifndef COP_CONSTS_SVH
`define COP_CONSTS_SVH

// RISC-V custom-0 major opcode
`define COP_OPCODE      7'b0001011

// Number of coprocessor registers
`define COP_NREGS       16

// Result codes returned with each response
`define COP_RES_SUCCESS 3'd0
`define COP_RES_BAD_INS 3'd1    // Illegal instruction

`endif

//--- logic/cop_pkg.sv
//////////////////////////////////////////////////
// Types shared by the coprocessor blocks and the
// testbench. Referenced by scoped name.
//////////////////////////////////////////////////

`include "cop_consts.svh"

package cop_pkg;

    typedef enum logic [3:0] {
        CLS_PACKED  = 4'd1,                         // Lane-wise add / sub
        CLS_BITWISE = 4'd2,                         // Logic ops
        CLS_MOVE    = 4'd3                          // GPR <-> CPR moves
    } cop_class_e;

    // Subclass values overlap between classes
    typedef logic [2:0] cop_sub_e;
    localparam cop_sub_e SUB_ADD     = 3'd0;        // Packed
    localparam cop_sub_e SUB_SUB     = 3'd1;
    localparam cop_sub_e SUB_AND     = 3'd0;        // Bitwise
    localparam cop_sub_e SUB_OR      = 3'd1;
    localparam cop_sub_e SUB_XOR     = 3'd2;
    localparam cop_sub_e SUB_NOT     = 3'd3;
    localparam cop_sub_e SUB_GPR2XCR = 3'd0;        // Move
    localparam cop_sub_e SUB_XCR2GPR = 3'd1;

    typedef enum logic [2:0] {
        PW32 = 3'd0, PW16 = 3'd1, PW8 = 3'd2, PW4 = 3'd3, PW2 = 3'd4
    } cop_pw_e;                                     // Codes 5..7 illegal

    typedef struct packed {
        cop_class_e  cls;                           // [31:28]
        cop_sub_e    sub;                           // [27:25]
        cop_pw_e     pw;                            // [24:22]
        logic [1:0]  rsvd_hi;
        logic [3:0]  crs2;                          // [19:16]
        logic [3:0]  crs1;                          // [15:12]
        logic [3:0]  crd;                           // [11:8]
        logic        rsvd_lo;
        logic [6:0]  opcode;
    } cop_r_form_t;

    typedef struct packed {
        cop_class_e  cls;
        cop_sub_e    sub;
        logic [4:0]  rd;                            // GPR number in [24:20]
        logic [3:0]  rsvd_hi;
        logic [3:0]  crs1;
        logic [3:0]  crd;
        logic        rsvd_lo;
        logic [6:0]  opcode;
    } cop_m_form_t;

    // Bits 24..20 are pack width or GPR depending on class
    typedef union packed {
        cop_r_form_t r_form;                        // Packed and bitwise
        cop_m_form_t m_form;                        // Moves
    } cop_insn_u;

    typedef struct packed {
        logic        illegal;
        cop_class_e  cls;
        cop_sub_e    sub;
        cop_pw_e     pw;
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [3:0]  crd;
        logic [4:0]  rd;
    } cop_dec_t;

    typedef struct packed {
        cop_insn_u   insn;
        logic [31:0] rs1;                           // GPR source value
    } cop_req_t;

    typedef struct packed {
        logic        wen;                           // GPR writeback
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [2:0]  result;
    } cop_rsp_t;

    typedef struct packed {
        logic                          wen;
        logic [$clog2(`COP_NREGS)-1:0] addr;
        logic [31:0]                   wdata;
    } cpr_wr_t;

endpackage

//--- logic/cop_decode.sv
//////////////////////////////////////////////////
// Instruction decoder. Purely combinational, picks
// the union view from the class field.
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cop_consts.svh"

module cop_decode (
    input  cop_pkg::cop_insn_u i_insn,              // Raw instruction word
    output cop_pkg::cop_dec_t  o_dec                // Decoded fields
);

    always_comb begin
        // Fields common to both forms
        o_dec.cls     = i_insn.r_form.cls;
        o_dec.sub     = i_insn.r_form.sub;
        o_dec.crs1    = i_insn.r_form.crs1;
        o_dec.crd     = i_insn.r_form.crd;

        if (i_insn.r_form.cls == cop_pkg::CLS_MOVE) begin
            o_dec.pw   = cop_pkg::PW32;             // Unused for moves
            o_dec.crs2 = '0;
            o_dec.rd   = i_insn.m_form.rd;
        end else begin
            o_dec.pw   = i_insn.r_form.pw;
            o_dec.crs2 = i_insn.r_form.crs2;
            o_dec.rd   = '0;                        // No GPR target
        end

        o_dec.illegal = (i_insn.r_form.opcode != `COP_OPCODE);
        case (i_insn.r_form.cls)
            cop_pkg::CLS_PACKED: begin
                if (i_insn.r_form.sub > cop_pkg::SUB_SUB)
                    o_dec.illegal = 1'b1;
                if (i_insn.r_form.pw > cop_pkg::PW2)
                    o_dec.illegal = 1'b1;           // Codes 5..7
            end
            cop_pkg::CLS_BITWISE: begin
                if (i_insn.r_form.sub > cop_pkg::SUB_NOT)
                    o_dec.illegal = 1'b1;
            end
            cop_pkg::CLS_MOVE: begin
                if (i_insn.m_form.sub > cop_pkg::SUB_XCR2GPR)
                    o_dec.illegal = 1'b1;
            end
            default: begin
                o_dec.illegal = 1'b1;               // Unknown class
            end
        endcase
    end

endmodule

//--- logic/cop_cprs.sv
//////////////////////////////////////////////////
// Coprocessor register file. Two async reads,
// one write port, cleared in reset.
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cop_consts.svh"

module cop_cprs (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic [3:0]        i_crs1_addr,          // Read port 1
    input  logic [3:0]        i_crs2_addr,          // Read port 2
    output logic [31:0]       o_crs1_rdata,
    output logic [31:0]       o_crs2_rdata,
    input  cop_pkg::cpr_wr_t  i_wr                  // Full word write
);

    logic [31:0] cprs [`COP_NREGS];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NREGS; i++) begin
                cprs[i] <= '0;
            end
        end else if (i_wr.wen) begin
            cprs[i_wr.addr] <= i_wr.wdata;          // Seen next cycle
        end
    end

    // No bypass from the write port
    assign o_crs1_rdata = cprs[i_crs1_addr];
    assign o_crs2_rdata = cprs[i_crs2_addr];

endmodule

//--- logic/cop_palu.sv
//////////////////////////////////////////////////
// Packed arithmetic and bitwise unit. Combinational,
// lane width set by the decoded pack width.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cop_palu (
    input  cop_pkg::cop_dec_t i_dec,                // Decoded instruction
    input  logic [31:0]       i_rs1,                // CPR operand 1
    input  logic [31:0]       i_rs2,                // CPR operand 2
    output logic [31:0]       o_result
);

    logic [31:0] arith;                             // Lane-wise sum / diff
    logic [31:0] logic_res;

    // Ripple through all 32 bits with the carry restarting at each lane
    always_comb begin
        logic       sub;
        logic       carry;
        logic       b;
        logic [4:0] lane_mask;

        sub       = (i_dec.sub == cop_pkg::SUB_SUB);
        lane_mask = 5'h1F >> i_dec.pw;              // Lane width minus one
        carry     = sub;
        arith     = '0;
        for (int i = 0; i < 32; i++) begin
            if ((5'(i) & lane_mask) == 5'd0)
                carry = sub;                        // No carry into a lane start
            b        = sub ? ~i_rs2[i] : i_rs2[i];  // a + ~b + 1 for subtract
            arith[i] = i_rs1[i] ^ b ^ carry;
            carry    = (i_rs1[i] & b) | (i_rs1[i] & carry) | (b & carry);
        end
    end

    always_comb begin
        case (i_dec.sub)
            cop_pkg::SUB_AND: logic_res = i_rs1 & i_rs2;
            cop_pkg::SUB_OR:  logic_res = i_rs1 | i_rs2;
            cop_pkg::SUB_XOR: logic_res = i_rs1 ^ i_rs2;
            cop_pkg::SUB_NOT: logic_res = ~i_rs1;   // Operand 2 ignored
            default:          logic_res = '0;
        endcase
    end

    always_comb begin
        case (i_dec.cls)
            cop_pkg::CLS_PACKED:  o_result = arith;
            cop_pkg::CLS_BITWISE: o_result = logic_res;
            default:              o_result = '0;    // Moves bypass the unit
        endcase
    end

endmodule

//--- logic/cop_ctrl.sv
//////////////////////////////////////////////////
// Handshake FSM and writeback control. Every
// instruction completes in its accept cycle.
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cop_consts.svh"

module cop_ctrl (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              i_cpu_insn_req,       // CPU request valid
    output logic              o_cop_insn_ack,       // Ready to accept
    input  logic [31:0]       i_gpr_rs1,            // GPR operand
    input  cop_pkg::cop_dec_t i_dec,
    input  logic [31:0]       i_crs1_rdata,
    input  logic [31:0]       i_palu_result,
    output cop_pkg::cpr_wr_t  o_cpr_wr,             // CPR writeback
    output logic              o_cop_insn_rsp,       // Response valid
    output cop_pkg::cop_rsp_t o_rsp,
    input  logic              i_cpu_insn_ack        // CPU took response
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,                            // Leaving reset
        WAITING  = 2'd1,                            // Ack high until a request
        FINISHED = 2'd2                             // Rsp held until taken
    } state_e;

    state_e            state;
    state_e            n_state;
    logic              n_ack;
    logic              n_rsp;
    logic              accept;
    logic              retire;
    logic              is_x2g;
    logic              is_g2x;
    cop_pkg::cop_rsp_t rsp_next;

    assign accept = i_cpu_insn_req && o_cop_insn_ack;
    assign retire = o_cop_insn_rsp && i_cpu_insn_ack;

    assign is_x2g = (i_dec.cls == cop_pkg::CLS_MOVE) && (i_dec.sub == cop_pkg::SUB_XCR2GPR);
    assign is_g2x = (i_dec.cls == cop_pkg::CLS_MOVE) && (i_dec.sub == cop_pkg::SUB_GPR2XCR);

    always_comb begin
        n_state = state;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            IDLE: n_state = WAITING;                // Ack rises one edge later
            WAITING: begin
                if (accept) begin
                    n_state = FINISHED;
                    n_rsp   = 1'b1;
                end else begin
                    n_ack   = 1'b1;
                end
            end
            FINISHED: begin
                if (retire) begin
                    n_state = WAITING;
                    n_ack   = 1'b1;
                end else begin
                    n_rsp   = 1'b1;                 // Back-pressure
                end
            end
            default: n_state = IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state          <= IDLE;
            o_cop_insn_ack <= 1'b0;
            o_cop_insn_rsp <= 1'b0;
        end else begin
            state          <= n_state;
            o_cop_insn_ack <= n_ack;
            o_cop_insn_rsp <= n_rsp;
        end
    end

    // XCR2GPR only returns a GPR value
    always_comb begin
        rsp_next.wen    = !i_dec.illegal && is_x2g;
        rsp_next.waddr  = i_dec.rd;
        rsp_next.wdata  = rsp_next.wen ? i_crs1_rdata : '0;
        rsp_next.result = i_dec.illegal ? `COP_RES_BAD_INS : `COP_RES_SUCCESS;
    end

    always_ff @(posedge g_clk) begin
        if (accept)
            o_rsp <= rsp_next;                      // Stable while rsp is high
    end

    // CPR write lands on the accept edge
    assign o_cpr_wr.wen   = accept && !i_dec.illegal && !is_x2g;
    assign o_cpr_wr.addr  = i_dec.crd;
    assign o_cpr_wr.wdata = is_g2x ? i_gpr_rs1 : i_palu_result;

endmodule

//--- logic/cop_top.sv
//////////////////////////////////////////////////
// Coprocessor top level. Connects the decoder, CPR
// file, packed unit and handshake controller.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cop_top (
    input  logic              g_clk,
    input  logic              g_resetn,             // Sync, active low
    input  logic              i_cpu_insn_req,       // Request from CPU
    output logic              o_cop_insn_ack,
    input  cop_pkg::cop_req_t i_req,                // Insn and GPR rs1
    output logic              o_cop_insn_rsp,       // Response to CPU
    output cop_pkg::cop_rsp_t o_rsp,
    input  logic              i_cpu_insn_ack
);

    cop_pkg::cop_dec_t dec;                         // Decoded request
    cop_pkg::cpr_wr_t  cpr_wr;
    logic [31:0]       crs1_rdata;
    logic [31:0]       crs2_rdata;
    logic [31:0]       palu_result;

    cop_decode cop_decode_inst (
        .i_insn         (i_req.insn),
        .o_dec          (dec)
    );

    cop_cprs cop_cprs_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_crs1_addr    (dec.crs1),
        .i_crs2_addr    (dec.crs2),
        .o_crs1_rdata   (crs1_rdata),
        .o_crs2_rdata   (crs2_rdata),
        .i_wr           (cpr_wr)
    );

    cop_palu cop_palu_inst (
        .i_dec          (dec),
        .i_rs1          (crs1_rdata),
        .i_rs2          (crs2_rdata),
        .o_result       (palu_result)
    );

    cop_ctrl cop_ctrl_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_cpu_insn_req (i_cpu_insn_req),
        .o_cop_insn_ack (o_cop_insn_ack),
        .i_gpr_rs1      (i_req.rs1),                // For GPR2XCR
        .i_dec          (dec),
        .i_crs1_rdata   (crs1_rdata),               // For XCR2GPR
        .i_palu_result  (palu_result),
        .o_cpr_wr       (cpr_wr),
        .o_cop_insn_rsp (o_cop_insn_rsp),
        .o_rsp          (o_rsp),
        .i_cpu_insn_ack (i_cpu_insn_ack)
    );

endmodule

//--- test/tb_cop_top.sv
//////////////////////////////////////////////////
// Self-checking testbench for the coprocessor top.
// Shadows the CPRs, checks handshake and data by assertion.
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cop_consts.svh"

module tb_cop_top;

    logic              g_clk;
    logic              g_resetn;
    logic              i_cpu_insn_req;
    logic              o_cop_insn_ack;
    cop_pkg::cop_req_t i_req;
    logic              o_cop_insn_rsp;
    cop_pkg::cop_rsp_t o_rsp;
    logic              i_cpu_insn_ack;
    cop_pkg::cop_rsp_t exp_rsp;                     // Expected payload of next rsp
    logic [31:0]       cpr_model [`COP_NREGS];      // Shadow CPRs
    logic [1:0]        rel_cnt;                     // Edges since reset release
    integer            seed;
    int                errors = 0;
    int                tests  = 0;
    int                t0     = 0;                  // Errors before current test
    wire               accept = i_cpu_insn_req && o_cop_insn_ack;

    cop_top cop_top_inst (.*);

    always #50 g_clk = ~g_clk;                      // 100 ns period

    always @(posedge g_clk) begin
        if (!g_resetn)
            rel_cnt <= 2'd0;
        else if (rel_cnt != 2'd3)
            rel_cnt <= rel_cnt + 2'd1;              // Saturates
    end

    task automatic report_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    a_reset_quiet: assert property (@(posedge g_clk)
        !g_resetn |=> !o_cop_insn_ack && !o_cop_insn_rsp)
        else report_error("ack or rsp high during reset");
    a_ack_rise: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (rel_cnt == 2'd1 || rel_cnt == 2'd2) |-> (o_cop_insn_ack == (rel_cnt == 2'd2)))
        else report_error("ack not high on second edge after reset");
    a_rsp_follows: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accept |=> o_cop_insn_rsp)
        else report_error("rsp missing one cycle after accept");
    a_rsp_cause: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(o_cop_insn_rsp) |-> $past(accept))
        else report_error("rsp rose without accept");
    a_ack_low: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_cop_insn_rsp |-> !o_cop_insn_ack)
        else report_error("ack high while rsp high");
    a_stall_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_cop_insn_rsp && !i_cpu_insn_ack)
            |=> o_cop_insn_rsp && $stable(o_rsp) && !o_cop_insn_ack)
        else report_error("rsp not held under back-pressure");
    a_retire: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_cop_insn_rsp && i_cpu_insn_ack) |=> !o_cop_insn_rsp && o_cop_insn_ack)
        else report_error("ack not back after retirement");
    a_payload: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_cop_insn_rsp |-> (o_rsp == exp_rsp))
        else report_error("rsp payload differs from model");

    // Lane-wise add or subtract that wraps inside each lane
    function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                               input logic [2:0] pw, input logic sub);
        int          w;
        logic [31:0] mask;
        logic [31:0] la;
        logic [31:0] lb;
        logic [31:0] res;
        w    = 32 >> pw;
        mask = (w == 32) ? 32'hFFFF_FFFF : (32'd1 << w) - 32'd1;
        res  = '0;
        for (int k = 0; k < 32; k += w) begin
            la  = (a >> k) & mask;
            lb  = (b >> k) & mask;
            res = res | (((sub ? la - lb : la + lb) & mask) << k);
        end
        return res;
    endfunction

    function automatic cop_pkg::cop_rsp_t rsp_word(input logic wen, input logic [4:0] waddr,
                                                   input logic [31:0] wdata, input logic [2:0] res);
        return {wen, waddr, wdata, res};
    endfunction

    function automatic logic [31:0] r_insn(input logic [3:0] cls, input logic [2:0] sub,
                                           input logic [2:0] pw, input logic [3:0] crs1,
                                           input logic [3:0] crs2, input logic [3:0] crd,
                                           input logic [6:0] opc);
        return {cls, sub, pw, 2'b00, crs2, crs1, crd, 1'b0, opc};
    endfunction

    function automatic logic [31:0] m_insn(input logic [2:0] sub, input logic [4:0] rd,
                                           input logic [3:0] crs1, input logic [3:0] crd);
        return {cop_pkg::CLS_MOVE, sub, rd, 4'b0000, crs1, crd, 1'b0, `COP_OPCODE};
    endfunction

    // One full request / response exchange
    task automatic issue(input logic [31:0] insn, input logic [31:0] gpr,
                         input cop_pkg::cop_rsp_t exp, input int stall);
        @(negedge g_clk);
        while (!o_cop_insn_ack)
            @(negedge g_clk);
        exp_rsp        = exp;
        i_req          = {insn, gpr};
        i_cpu_insn_req = 1'b1;
        @(negedge g_clk);
        i_cpu_insn_req = 1'b0;
        i_req          = {$random(seed), $random(seed)};  // Payload only valid at accept
        while (!o_cop_insn_rsp)
            @(negedge g_clk);
        repeat (stall) @(negedge g_clk);            // CPU back-pressure
        i_cpu_insn_ack = 1'b1;
        @(negedge g_clk);
        i_cpu_insn_ack = 1'b0;
    endtask

    task automatic load_cpr(input logic [3:0] crd, input logic [31:0] v);
        issue(m_insn(cop_pkg::SUB_GPR2XCR, 5'd0, 4'd0, crd), v,
              rsp_word(1'b0, 5'd0, 32'd0, `COP_RES_SUCCESS), 0);
        cpr_model[crd] = v;
    endtask

    task automatic read_cpr(input logic [3:0] crs, input int stall);
        logic [4:0] rd;
        rd = 5'($random(seed)) | 5'd1;              // Nonzero GPR
        issue(m_insn(cop_pkg::SUB_XCR2GPR, rd, crs, 4'd0), $random(seed),
              rsp_word(1'b1, rd, cpr_model[crs], `COP_RES_SUCCESS), stall);
    endtask

    task automatic run_alu(input logic [3:0] cls, input logic [2:0] sub, input logic [2:0] pw,
                           input logic [3:0] crs1, input logic [3:0] crs2, input logic [3:0] crd);
        logic [31:0] a;
        logic [31:0] b;
        a = cpr_model[crs1];
        b = cpr_model[crs2];
        issue(r_insn(cls, sub, pw, crs1, crs2, crd, `COP_OPCODE), $random(seed),
              rsp_word(1'b0, 5'd0, 32'd0, `COP_RES_SUCCESS), 0);
        if (cls == cop_pkg::CLS_PACKED) begin
            cpr_model[crd] = lane_arith(a, b, pw, sub == cop_pkg::SUB_SUB);
        end else begin
            case (sub)
                cop_pkg::SUB_AND: cpr_model[crd] = a & b;
                cop_pkg::SUB_OR:  cpr_model[crd] = a | b;
                cop_pkg::SUB_XOR: cpr_model[crd] = a ^ b;
                default:          cpr_model[crd] = ~a;
            endcase
        end
        read_cpr(crd, 0);                           // Result via XCR2GPR
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - t0);
        t0 = errors;
    endtask

    initial begin
        repeat (2000) @(posedge g_clk);             // About ten times the test length
        $display("Timeout: the run did not finish within 2000 cycles");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int          stall;
        logic [31:0] r;
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        i_cpu_insn_req = 1'b0;
        i_cpu_insn_ack = 1'b0;
        i_req          = '0;
        exp_rsp        = '0;
        seed           = 32'h55b1;
        for (int i = 0; i < `COP_NREGS; i++)
            cpr_model[i] = '0;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        repeat (4) @(negedge g_clk);
        finish_test("reset_handshake");
        repeat (4) begin
            r = $random(seed);
            load_cpr(r[3:0], $random(seed));
            read_cpr(r[3:0], 0);
        end
        finish_test("move_round_trip");
        load_cpr(4'd1, $random(seed));
        load_cpr(4'd2, $random(seed));
        for (int pw = 0; pw < 5; pw++) begin
            r = $random(seed);
            run_alu(cop_pkg::CLS_PACKED, cop_pkg::SUB_ADD, 3'(pw), 4'd1, 4'd2, 4'(3 + r % 12));
            run_alu(cop_pkg::CLS_PACKED, cop_pkg::SUB_SUB, 3'(pw), 4'd1, 4'd2, 4'(3 + r % 12));
        end
        finish_test("packed_arith");
        load_cpr(4'd1, $random(seed));
        load_cpr(4'd2, $random(seed));
        for (int s = 0; s < 4; s++)
            run_alu(cop_pkg::CLS_BITWISE, 3'(s), 3'd0, 4'd1, 4'd2, 4'd4);
        finish_test("bitwise");
        load_cpr(4'd5, $random(seed));              // Target that must survive
        issue(r_insn(cop_pkg::CLS_PACKED, cop_pkg::SUB_ADD, cop_pkg::PW32, 4'd1, 4'd2, 4'd5,
                     7'b0110011), $random(seed), rsp_word(1'b0, 5'd0, 32'd0, `COP_RES_BAD_INS), 0);
        issue(r_insn(cop_pkg::CLS_PACKED, cop_pkg::SUB_ADD, 3'd6, 4'd1, 4'd2, 4'd5, `COP_OPCODE),
              $random(seed), rsp_word(1'b0, 5'd0, 32'd0, `COP_RES_BAD_INS), 0);
        issue(r_insn(4'd9, 3'd0, 3'd0, 4'd1, 4'd2, 4'd5, `COP_OPCODE),
              $random(seed), rsp_word(1'b0, 5'd0, 32'd0, `COP_RES_BAD_INS), 0);
        read_cpr(4'd5, 0);
        finish_test("illegal_insn");
        repeat (6) begin
            r     = $random(seed);
            stall = 1 + int'(r % 10);               // 1 to 10 cycles
            read_cpr(r[11:8], stall);
        end
        finish_test("back_pressure");
        repeat (2) @(negedge g_clk);
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/cop_pkg.sv
logic/cop_decode.sv
logic/cop_cprs.sv
logic/cop_palu.sv
logic/cop_ctrl.sv
logic/cop_top.sv
test/tb_cop_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cop_top -f compile.f \
    && ./obj_dir/Vtb_cop_top > sim.log 2>&1
grep -qs "All tests passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
